//--- sim/fetch_trace.txt
# M word_addr data | R instr_count src(0 jump 1 exc 2 eret) cause target | E pc instr
# boot address 00001000, reset vector 00001080
M 00001000 30200073
M 00001004 00014505
M 00001080 46094505
M 00001084 00100513
M 00001088 81b30505
M 0000108c 47110020
M 00001090 00c58593
M 000020a0 80820001
M 000020a4 00000013
M 000020a8 07b34781
M 000020ac 078900f7
R 7 0 0 000020a2
R 12 1 0 00000000
R 17 1 1 00000000
R 20 1 2 00000000
R 24 2 0 000020aa
R 26 1 3 00000000
E 00001080 00004505
E 00001082 00004609
E 00001084 00100513
E 00001088 00000505
E 0000108a 002081b3
E 0000108e 00004711
E 00001090 00c58593
E 000020a2 00008082
E 000020a4 00000013
E 000020a8 00004781
E 000020aa 00f707b3
E 000020ae 00000789
E 00001084 00100513
E 00001088 00000505
E 0000108a 002081b3
E 0000108e 00004711
E 00001090 00c58593
E 00001000 30200073
E 00001004 00004505
E 00001006 00000001
E 00001088 00000505
E 0000108a 002081b3
E 0000108e 00004711
E 00001090 00c58593
E 000020aa 00f707b3
E 000020ae 00000789
E 00001080 00004505
E 00001082 00004609
E 00001084 00100513
E 00001088 00000505
E 0000108a 002081b3
E 0000108e 00004711
E 00001090 00c58593

//--- list.f
+incdir+include
logic/fetch_pkg.sv
logic/instr_mem_port.sv
logic/fetch_realign.sv
logic/next_pc_sel.sv
logic/fetch_stage.sv
sim/fetch_clkgen.sv
sim/fetch_assertions.sv
sim/fetch_checker.sv
sim/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module fetch_tb -o fetch_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/fetch_tb_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -qx "All tests passed!" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see sim.log"
exit 1

//--- sim/fetch_tb.sv
////////////////////////////////////////////////////////////////////////////
// fetch stage testbench; memory, redirects and expected stream from sim/fetch_trace.txt
// redirects are placed where the old stream has just used up a word
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_tb
  import fetch_pkg::*;
();

  logic        clk, rst_n;
  logic        fetch_en_i = 1'b0;
  logic [31:0] boot_addr_i = 32'h0000_1000;
  logic        redirect_i = 1'b0;
  pc_src_e     pc_src_i = PC_JUMP;
  logic [31:0] redirect_pc_i = '0;
  exc_cause_e  exc_cause_i = EXC_ILLINSN;
  logic [31:0] eret_pc_i = '0;
  logic        instr_req_o, instr_valid_o, is_compressed_o;
  logic [31:0] instr_addr_o, instr_o, pc_o;
  logic        instr_gnt_i = 1'b0;
  logic        instr_rvalid_i = 1'b0;
  logic [31:0] instr_rdata_i = '0;
  logic        credit_return_i = 1'b0;

  // trace contents
  logic [31:0] mem_img [logic [31:0]];
  logic [31:0] exp_pc [0:63];
  logic [31:0] exp_instr [0:63];
  int          exp_n = 0;
  int          ev_idx [0:15];
  int          ev_src [0:15];
  int          ev_cause [0:15];
  logic [31:0] ev_pc [0:15];
  int          ev_n = 0;

  logic [31:0] lfsr_q = 32'hbc8f_4417;
  int          other_err = 0;
  int          err_total;
  logic        run_done = 1'b0;
  int          inst_cnt = 0;

  fetch_clkgen i_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  fetch_stage i_dut (
    .clk(clk), .rst_n(rst_n), .fetch_en_i(fetch_en_i), .boot_addr_i(boot_addr_i),
    .redirect_i(redirect_i), .pc_src_i(pc_src_i), .redirect_pc_i(redirect_pc_i),
    .exc_cause_i(exc_cause_i), .eret_pc_i(eret_pc_i),
    .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o), .instr_gnt_i(instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i), .instr_rdata_i(instr_rdata_i),
    .instr_valid_o(instr_valid_o), .instr_o(instr_o), .pc_o(pc_o),
    .is_compressed_o(is_compressed_o), .credit_return_i(credit_return_i)
  );

  fetch_checker i_checker (
    .clk(clk), .rst_n(rst_n), .valid_i(instr_valid_o), .instr_i(instr_o), .pc_i(pc_o),
    .compressed_i(is_compressed_o), .exp_n_i(exp_n), .exp_pc_i(exp_pc),
    .exp_instr_i(exp_instr), .other_err_i(other_err), .done_i(run_done),
    .err_total_o(err_total)
  );

  bind fetch_stage fetch_assertions i_fetch_assertions (
    .clk(clk), .rst_n(rst_n), .req_i(instr_req_o), .addr_i(instr_addr_o),
    .gnt_i(instr_gnt_i), .rvalid_i(instr_rvalid_i), .valid_i(instr_valid_o),
    .credit_ret_i(credit_return_i)
  );

  // fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  function automatic int unsigned draw_bits(input int unsigned n);
    int unsigned v;
    v = 0;
    for (int unsigned k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  // unknown addresses answer with a pattern built from the whole address
  function automatic fetch_word_u mem_read(input logic [31:0] addr);
    fetch_word_u w;
    if (mem_img.exists(addr)) begin
      w.full = mem_img[addr];
    end else begin
      w.parcel.hi = addr[31:16] ^ 16'ha5c3;
      w.parcel.lo = addr[15:0] ^ 16'h3c5a;
    end
    return w;
  endfunction

  task automatic load_trace();
    int          fd;
    int          n;
    int          idx, src, cause;
    string       line, rest;
    logic [31:0] a, b;
    fd = $fopen("sim/fetch_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/fetch_trace.txt");
      other_err++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() < 3 || line.getc(0) == "#") begin
        continue;
      end
      rest = line.substr(2, line.len() - 1);
      if (line.getc(0) == "M") begin
        n = $sscanf(rest, "%h %h", a, b);
        mem_img[a] = b;
      end else if (line.getc(0) == "E" && exp_n < 64) begin
        n = $sscanf(rest, "%h %h", a, b);
        exp_pc[exp_n] = a;
        exp_instr[exp_n] = b;
        exp_n++;
      end else if (line.getc(0) == "R" && ev_n < 16) begin
        n = $sscanf(rest, "%d %d %d %h", idx, src, cause, a);
        ev_idx[ev_n] = idx;
        ev_src[ev_n] = src;
        ev_cause[ev_n] = cause;
        ev_pc[ev_n] = a;
        ev_n++;
      end
    end
    $fclose(fd);
  endtask

  // advance one cycle and count what decode took
  task automatic step_cycle();
    @(posedge clk);
    if (instr_valid_o) begin
      inst_cnt++;
    end
  endtask

  task automatic run_to_count(input int target, output bit ok);
    int waited;
    waited = 0;
    while (inst_cnt < target && waited < 500) begin
      step_cycle();
      waited++;
    end
    ok = (inst_cnt >= target);
    if (!ok) begin
      $display("timed out waiting for instruction %0d, only %0d arrived", target, inst_cnt);
      other_err++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory model with grant after 0..3 cycles and rvalid 1..2 cycles later
  ////////////////////////////////////////////////////////////////////////////
  int          mstate = 0;
  int unsigned mdly;

  always @(posedge clk) begin
    if (!rst_n) begin
      mstate = 0;
      instr_gnt_i <= 1'b0;
      instr_rvalid_i <= 1'b0;
    end else begin
      case (mstate)
        0: if (instr_req_o) begin
          mdly = draw_bits(2);
          if (mdly == 0) begin
            instr_gnt_i <= 1'b1;
            mstate = 2;
          end else begin
            mstate = 1;
          end
        end
        1: begin
          mdly--;
          if (mdly == 0) begin
            instr_gnt_i <= 1'b1;
            mstate = 2;
          end
        end
        // grant sampled here while the address is still valid
        2: begin
          instr_gnt_i <= 1'b0;
          instr_rdata_i <= mem_read(instr_addr_o);
          if (draw_bits(1) == 0) begin
            instr_rvalid_i <= 1'b1;
            mstate = 4;
          end else begin
            mstate = 3;
          end
        end
        3: begin
          instr_rvalid_i <= 1'b1;
          mstate = 4;
        end
        default: begin
          instr_rvalid_i <= 1'b0;
          mstate = 0;
        end
      endcase
    end
  end

  // decode model returns credits at random outside a hold window
  int pending = 0;
  int ccycle = 0;

  always @(posedge clk) begin
    if (!rst_n) begin
      pending = 0;
      credit_return_i <= 1'b0;
    end else begin
      ccycle++;
      pending = pending + int'(instr_valid_o) - int'(credit_return_i);
      if (!(ccycle >= 60 && ccycle < 110) && pending > 0 && draw_bits(1) == 1) begin
        credit_return_i <= 1'b1;
      end else begin
        credit_return_i <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int waited;
    bit ok;
    ok = 1'b1;
    waited = 0;
    load_trace();
    while (!rst_n && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      $display("reset was never released");
      other_err++;
      ok = 1'b0;
    end
    step_cycle();
    fetch_en_i <= 1'b1;
    for (int e = 0; e < ev_n && ok; e++) begin
      run_to_count(ev_idx[e], ok);
      if (ok) begin
        // odd events come one cycle late while the next word is still in flight
        if (e % 2 == 1) begin
          step_cycle();
        end
        redirect_i <= 1'b1;
        pc_src_i <= pc_src_e'(ev_src[e]);
        exc_cause_i <= exc_cause_e'(ev_cause[e]);
        redirect_pc_i <= ev_pc[e];
        eret_pc_i <= ev_pc[e];
        step_cycle();
        redirect_i <= 1'b0;
      end
    end
    if (ok) begin
      run_to_count(exp_n, ok);
    end
    // stop fetching and flush so anything after this is extra
    redirect_i <= 1'b1;
    fetch_en_i <= 1'b0;
    step_cycle();
    redirect_i <= 1'b0;
    repeat (40) step_cycle();
    run_done = 1'b1;
    repeat (2) @(posedge clk);
    if (err_total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- sim/fetch_checker.sv
////////////////////////////////////////////////////////////////////////////
// compares decode-side output with the expected stream, up to 64 entries
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_checker
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        valid_i,
  input  logic [31:0] instr_i,
  input  logic [31:0] pc_i,
  input  logic        compressed_i,
  input  int          exp_n_i,
  input  logic [31:0] exp_pc_i [0:63],
  input  logic [31:0] exp_instr_i [0:63],
  input  int          other_err_i,
  input  logic        done_i,
  output int          err_total_o
);

  int          idx = 0;
  int          mismatch_cnt = 0;
  int          missing_cnt = 0;
  int          extra_cnt = 0;
  logic        reported = 1'b0;
  fetch_word_u exp_w;
  logic        exp_c;

  initial err_total_o = 0;

  always @(posedge clk) begin
    if (rst_n && valid_i) begin
      if (idx >= exp_n_i) begin
        extra_cnt++;
        $display("extra instruction at %0t with pc %08h beyond the expected stream",
                 $time, pc_i);
      end else begin
        exp_w.full = exp_instr_i[idx];
        // low bits of the first parcel tell the instruction width
        exp_c = (exp_w.parcel.lo[1:0] != `RVC_FULL_MARK);
        if (pc_i !== exp_pc_i[idx]) begin
          mismatch_cnt++;
          $display("mismatch at %0t: pc_o got %08h expected %08h",
                   $time, pc_i, exp_pc_i[idx]);
        end
        if (instr_i !== exp_instr_i[idx]) begin
          mismatch_cnt++;
          $display("mismatch at %0t: instr_o got %08h expected %08h",
                   $time, instr_i, exp_instr_i[idx]);
        end
        if (compressed_i !== exp_c) begin
          mismatch_cnt++;
          $display("mismatch at %0t: is_compressed_o got %0b expected %0b",
                   $time, compressed_i, exp_c);
        end
      end
      idx++;
    end
    // closing summary once the run is over
    if (done_i && !reported) begin
      reported = 1'b1;
      if (idx < exp_n_i) begin
        missing_cnt = exp_n_i - idx;
        $display("%0d expected instructions never came out, first at pc %08h",
                 missing_cnt, exp_pc_i[idx]);
      end
      err_total_o = mismatch_cnt + missing_cnt + extra_cnt + other_err_i;
      $display("errors: mismatch %0d, missing %0d, extra %0d, other %0d",
               mismatch_cnt, missing_cnt, extra_cnt, other_err_i);
    end
  end

endmodule

//--- sim/fetch_assertions.sv
////////////////////////////////////////////////////////////////////////////
// bus protocol and credit limit checks bound into fetch_stage
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic        req_i,
  input logic [31:0] addr_i,
  input logic        gnt_i,
  input logic        rvalid_i,
  input logic        valid_i,
  input logic        credit_ret_i
);

  logic outstanding_q;
  int   in_flight_q;

  // one granted access waits for its rvalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 1'b0;
      in_flight_q   <= 0;
    end else begin
      if (req_i && gnt_i) begin
        outstanding_q <= 1'b1;
      end else if (rvalid_i) begin
        outstanding_q <= 1'b0;
      end
      // instructions handed to decode and not yet returned
      in_flight_q <= in_flight_q + int'(valid_i) - int'(credit_ret_i);
    end
  end

  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req_i && !gnt_i |=> req_i && $stable(addr_i))
    else $error("request or address changed before grant");

  // no new request may be granted until the pending rvalid arrives
  single_access: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q |-> !req_i)
    else $error("new request while an access is outstanding");

  credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
    in_flight_q <= `FETCH_CREDITS)
    else $error("more instructions in flight than decode credits");

endmodule

//--- sim/fetch_clkgen.sv
////////////////////////////////////////////////////////////////////////////
// 40 ns clock, reset held low for the first 4 rising edges
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
  end

  always #20 clk_o = ~clk_o;

  // release on an edge so the DUT sees a clean first cycle
  initial begin
    repeat (4) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- logic/fetch_stage.sv
////////////////////////////////////////////////////////////////////////////
// fetch stage top, memory bus on one side and credit-based decode on the other
// decode starts with FETCH_CREDITS credits after reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_stage
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_en_i,
  input  logic [31:0] boot_addr_i,
  // redirect request, one cycle pulse
  input  logic        redirect_i,
  input  pc_src_e     pc_src_i,
  input  logic [31:0] redirect_pc_i,
  input  exc_cause_e  exc_cause_i,
  input  logic [31:0] eret_pc_i,
  // memory bus
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  // decode side
  output logic        instr_valid_o,
  output logic [31:0] instr_o,
  output logic [31:0] pc_o,
  output logic        is_compressed_o,
  input  logic        credit_return_i
);

  logic [31:0] start_pc;
  logic [31:0] seq_pc;
  logic        mem_req;
  logic [31:0] mem_addr;
  logic        mem_ack;
  logic [31:0] mem_rdata;
  logic        flush;

  // restart address
  next_pc_sel i_next_pc_sel (
    .clk           (clk),
    .rst_n         (rst_n),
    .boot_addr_i   (boot_addr_i),
    .redirect_i    (redirect_i),
    .pc_src_i      (pc_src_i),
    .redirect_pc_i (redirect_pc_i),
    .exc_cause_i   (exc_cause_i),
    .eret_pc_i     (eret_pc_i),
    .seq_pc_i      (seq_pc),
    .start_pc_o    (start_pc)
  );

  // realigner and credit counter
  fetch_realign i_fetch_realign (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_en_i      (fetch_en_i),
    .redirect_i      (redirect_i),
    .start_pc_i      (start_pc),
    .mem_ack_i       (mem_ack),
    .mem_rdata_i     (mem_rdata),
    .mem_req_o       (mem_req),
    .mem_addr_o      (mem_addr),
    .flush_o         (flush),
    .seq_pc_o        (seq_pc),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .pc_o            (pc_o),
    .is_compressed_o (is_compressed_o),
    .credit_return_i (credit_return_i)
  );

  // bus master
  instr_mem_port i_instr_mem_port (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (mem_req),
    .addr_i         (mem_addr),
    .flush_i        (flush),
    .ack_o          (mem_ack),
    .rdata_o        (mem_rdata),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

endmodule

//--- logic/next_pc_sel.sv
////////////////////////////////////////////////////////////////////////////
// restart address register; targets lose bit 0
// vectors are built from boot_addr_i[31:8] and the cause offset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_defs.svh"

module next_pc_sel
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] boot_addr_i,
  input  logic        redirect_i,
  input  pc_src_e     pc_src_i,
  input  logic [31:0] redirect_pc_i,
  input  exc_cause_e  exc_cause_i,
  input  logic [31:0] eret_pc_i,
  input  logic [31:0] seq_pc_i,
  output logic [31:0] start_pc_o
);

  logic        boot_q;
  logic [31:0] start_q, start_n;
  logic [31:0] rst_vec, exc_pc;

  assign rst_vec = {boot_addr_i[31:8], `EXC_OFF_RST};

  // exception vector by cause
  always_comb begin
    unique case (exc_cause_i)
      EXC_ILLINSN: exc_pc = {boot_addr_i[31:8], `EXC_OFF_ILLINSN};
      EXC_IRQ:     exc_pc = {boot_addr_i[31:8], `EXC_OFF_IRQ};
      EXC_IRQ_NM:  exc_pc = {boot_addr_i[31:8], `EXC_OFF_IRQ_NM};
      default:     exc_pc = rst_vec;
    endcase
  end

  // boot vector first, then redirect targets, else follow the realigner
  always_comb begin
    start_n = seq_pc_i;
    if (boot_q) begin
      start_n = rst_vec;
    end else if (redirect_i) begin
      unique case (pc_src_i)
        PC_JUMP: start_n = {redirect_pc_i[31:1], 1'b0};
        PC_EXC:  start_n = exc_pc;
        PC_ERET: start_n = {eret_pc_i[31:1], 1'b0};
        default: start_n = rst_vec;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_q  <= 1'b1;
      start_q <= '0;
    end else begin
      boot_q  <= 1'b0;
      start_q <= start_n;
    end
  end

  assign start_pc_o = start_q;

endmodule

//--- logic/fetch_realign.sv
////////////////////////////////////////////////////////////////////////////
// cuts 16/32-bit instructions out of fetched words, one word buffered
// valid is held back while no decode credit is left
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_realign
  import fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_en_i,
  input  logic        redirect_i,
  input  logic [31:0] start_pc_i,
  // memory port
  input  logic        mem_ack_i,
  input  logic [31:0] mem_rdata_i,
  output logic        mem_req_o,
  output logic [31:0] mem_addr_o,
  output logic        flush_o,
  // to next_pc_sel
  output logic [31:0] seq_pc_o,
  // decode side
  output logic        instr_valid_o,
  output logic [31:0] instr_o,
  output logic [31:0] pc_o,
  output logic        is_compressed_o,
  input  logic        credit_return_i
);

  localparam int unsigned CREDIT_W = $clog2(`FETCH_CREDITS + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RESTART,
    S_FILL,
    S_RUN,
    S_CROSS,
    S_SPLIT
  } rl_state_e;

  rl_state_e           state_q, state_n;
  fetch_word_u         buf_q, rdata_w;
  logic [15:0]         split_q;
  logic                off_q, off_n;
  logic [31:0]         pc_q, pc_n;
  logic [31:0]         addr_q, addr_n;
  logic [CREDIT_W-1:0] credit_q;
  logic [15:0]         cur_hw;
  logic                cur_full;
  logic                has_instr, issue;
  logic                load_buf, save_split;
  logic [31:0]         instr_d;
  logic                compressed_d;

  ////////////////////////////////////////////////////////////////////////////
  // instruction candidate
  ////////////////////////////////////////////////////////////////////////////
  assign rdata_w  = mem_rdata_i;
  // parcel at the current halfword offset
  assign cur_hw   = off_q ? buf_q.parcel.hi : buf_q.parcel.lo;
  assign cur_full = (cur_hw[1:0] == `RVC_FULL_MARK);

  always_comb begin
    has_instr    = 1'b0;
    instr_d      = buf_q.full;
    compressed_d = 1'b0;
    unique case (state_q)
      S_RUN: begin
        if (!cur_full) begin
          // 16-bit, upper half zero
          has_instr    = 1'b1;
          instr_d      = {16'h0000, cur_hw};
          compressed_d = 1'b1;
        end else if (!off_q) begin
          has_instr = 1'b1;
        end
      end
      // crossing instruction straight from the arriving word
      S_CROSS: begin
        has_instr = mem_ack_i;
        instr_d   = {rdata_w.parcel.lo, buf_q.parcel.hi};
      end
      // crossing instruction held while out of credits
      S_SPLIT: begin
        has_instr = 1'b1;
        instr_d   = {buf_q.parcel.lo, split_q};
      end
      default: begin
        has_instr = 1'b0;
      end
    endcase
  end

  assign issue           = has_instr && (credit_q != '0);
  assign instr_valid_o   = issue;
  assign instr_o         = instr_d;
  assign pc_o            = pc_q;
  assign is_compressed_o = compressed_d;

  ////////////////////////////////////////////////////////////////////////////
  // fetch FSM
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_n    = state_q;
    off_n      = off_q;
    addr_n     = addr_q;
    pc_n       = pc_q;
    load_buf   = 1'b0;
    save_split = 1'b0;
    mem_req_o  = 1'b0;
    mem_addr_o = addr_q;
    if (issue) begin
      pc_n = pc_q + (compressed_d ? 32'd2 : 32'd4);
    end
    unique case (state_q)
      S_IDLE: begin
        // track the restart point so next_pc_sel keeps it
        pc_n = start_pc_i;
        if (fetch_en_i) begin
          state_n = S_RESTART;
        end
      end
      S_RESTART: begin
        pc_n       = start_pc_i;
        off_n      = start_pc_i[1];
        addr_n     = {start_pc_i[31:2], 2'b00};
        mem_req_o  = 1'b1;
        mem_addr_o = {start_pc_i[31:2], 2'b00};
        state_n    = S_FILL;
      end
      S_FILL: begin
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          load_buf = 1'b1;
          addr_n   = addr_q + 32'd4;
          state_n  = S_RUN;
        end
      end
      S_RUN: begin
        if (!cur_full && !off_q) begin
          // lower 16-bit parcel, upper one still buffered
          if (issue) begin
            off_n = 1'b1;
          end
        end else if (cur_full && off_q) begin
          // upper parcel opens a 32-bit instruction, fetch the rest
          state_n = fetch_en_i ? S_CROSS : S_IDLE;
        end else if (issue) begin
          // word used up
          off_n   = 1'b0;
          state_n = fetch_en_i ? S_FILL : S_IDLE;
        end
      end
      S_CROSS: begin
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          load_buf = 1'b1;
          off_n    = 1'b1;
          addr_n   = addr_q + 32'd4;
          if (issue) begin
            state_n = S_RUN;
          end else begin
            save_split = 1'b1;
            state_n    = S_SPLIT;
          end
        end
      end
      S_SPLIT: begin
        if (issue) begin
          state_n = S_RUN;
        end
      end
      default: begin
        state_n = S_IDLE;
      end
    endcase
    // redirect drops the old stream, restart address comes next cycle
    if (redirect_i) begin
      mem_req_o = 1'b0;
      state_n   = fetch_en_i ? S_RESTART : S_IDLE;
    end
  end

  assign flush_o  = redirect_i;
  assign seq_pc_o = pc_n;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= S_IDLE;
      off_q    <= 1'b0;
      pc_q     <= '0;
      addr_q   <= '0;
      credit_q <= CREDIT_W'(`FETCH_CREDITS);
    end else begin
      state_q  <= state_n;
      off_q    <= off_n;
      pc_q     <= pc_n;
      addr_q   <= addr_n;
      // one credit out per issue, one back per return
      credit_q <= credit_q + CREDIT_W'(credit_return_i) - CREDIT_W'(issue);
    end
  end

  // word buffer and the saved upper parcel of a crossing instruction
  always_ff @(posedge clk) begin
    if (load_buf) begin
      buf_q <= rdata_w;
    end
    if (save_split) begin
      split_q <= buf_q.parcel.hi;
    end
  end

endmodule

//--- logic/instr_mem_port.sv
////////////////////////////////////////////////////////////////////////////
// req/gnt/rvalid master with a single outstanding access
// addr_i must be word aligned; a flushed access completes without ack
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module instr_mem_port (
  input  logic        clk,
  input  logic        rst_n,
  // realigner side
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        flush_i,
  output logic        ack_o,
  output logic [31:0] rdata_o,
  // memory bus
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i
);

  typedef enum logic [1:0] {
    P_IDLE,
    P_REQ,
    P_WAIT
  } port_state_e;

  port_state_e state_q, state_n;
  logic [31:0] addr_q;
  logic        stale_q, stale_n;
  logic        accept;

  // a new access starts only from idle
  assign accept = (state_q == P_IDLE) && req_i;

  // first request cycle goes straight out, later cycles use the latch
  assign instr_req_o  = accept || (state_q == P_REQ);
  assign instr_addr_o = (state_q == P_REQ) ? addr_q : addr_i;

  always_comb begin
    state_n = state_q;
    stale_n = stale_q;
    unique case (state_q)
      P_IDLE: begin
        if (accept) begin
          state_n = instr_gnt_i ? P_WAIT : P_REQ;
          stale_n = flush_i;
        end
      end
      P_REQ: begin
        // hold req and address until the grant
        if (instr_gnt_i) begin
          state_n = P_WAIT;
        end
        if (flush_i) begin
          stale_n = 1'b1;
        end
      end
      P_WAIT: begin
        if (instr_rvalid_i) begin
          state_n = P_IDLE;
          stale_n = 1'b0;
        end else if (flush_i) begin
          stale_n = 1'b1;
        end
      end
      default: begin
        state_n = P_IDLE;
      end
    endcase
  end

  // stale responses are swallowed here
  assign ack_o   = (state_q == P_WAIT) && instr_rvalid_i && !stale_q && !flush_i;
  assign rdata_o = instr_rdata_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= P_IDLE;
      stale_q <= 1'b0;
    end else begin
      state_q <= state_n;
      stale_q <= stale_n;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= addr_i;
    end
  end

endmodule

//--- logic/fetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// types shared by the fetch stage blocks
// encodings are fixed and not meant to be changed per instance
////////////////////////////////////////////////////////////////////////////
package fetch_pkg;

  // one instruction memory word
  // the realigner reads it as a whole or as two 16-bit parcels
  typedef union packed {
    logic [31:0] full;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } parcel;
  } fetch_word_u;

  // where a redirect takes its target from
  // encoding 2'b11 is unused and falls back to the reset vector
  typedef enum logic [1:0] {
    PC_JUMP = 2'd0,
    PC_EXC  = 2'd1,
    PC_ERET = 2'd2
  } pc_src_e;

  // exception cause, selects the vector offset
  typedef enum logic [1:0] {
    EXC_ILLINSN = 2'd0,
    EXC_IRQ     = 2'd1,
    EXC_IRQ_NM  = 2'd2,
    EXC_RST     = 2'd3
  } exc_cause_e;

endpackage

//--- include/fetch_defs.svh
////////////////////////////////////////////////////////////////////////////
// fetch stage constants; the design is built for these values only
// vector offsets replace the low byte of the boot address
////////////////////////////////////////////////////////////////////////////
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// decode queue depth, one credit per queue slot
`define FETCH_CREDITS 2

// exception vector offsets
// boot_addr_i[31:8] supplies the upper part of every vector
`define EXC_OFF_IRQ     8'h00
`define EXC_OFF_RST     8'h80
`define EXC_OFF_ILLINSN 8'h84
`define EXC_OFF_IRQ_NM  8'h88

// low two bits of a full 32-bit instruction
// any other pattern marks a 16-bit parcel
`define RVC_FULL_MARK 2'b11

`endif
